/* common/video_pkg.sv */
// Screen geometry definitions
package video_pkg;

    // the counters are sized for a full 256 pixel line.
    localparam int h_width = 8;
    localparam int v_width = 8;

    // pixels per line and lines per frame.
    // The frame is kept short so a whole frame fits a quick run.
    localparam int h_total = 256;
    localparam int v_total = 16;

    // hdump value at which the next line starts.
    // The fill of the following line also begins here.
    localparam int h_over = 255;

    // clk cycles per pixel.
    // pxl2_cen comes at twice the pixel rate.
    localparam int cen_div = 4;

    // width of the clock-enable divider counter.
    localparam int cen_width = $clog2(cen_div);

    // raster counter types.
    typedef logic [h_width-1:0] hpos_t;
    typedef logic [v_width-1:0] vpos_t;

endpackage

/* common/pixel_pkg.sv */
// Pixel and tile definitions
package pixel_pkg;

    // a pixel word is a palette field on top of a colour index.
    localparam int pal_width = 4;
    localparam int col_width = 4;
    localparam int pxl_width = pal_width + col_width;

    // tiles are 8x8 pixels and the map is 32x32 tiles.
    localparam int tile_bits    = 3;
    localparam int map_col_bits = 5;
    localparam int map_words    = 2 ** (2 * map_col_bits);

    typedef logic [pxl_width-1:0] pixel_t;
    typedef logic [7:0]           tile_code_t;

    // one map entry holds the palette and the tile code.
    typedef struct packed {
        logic [pal_width-1:0] pal;
        tile_code_t           code;
    } map_entry_t;

    // map address is the tile row followed by the tile column.
    typedef logic [2*map_col_bits-1:0] map_addr_t;

    // ROM address is the tile code followed by the row within the tile.
    typedef logic [$bits(tile_code_t)+tile_bits-1:0] rom_addr_t;

    // one ROM word is a tile row of eight nibbles, leftmost pixel lowest.
    typedef logic [31:0] rom_word_t;

endpackage

/* common/scan_if.sv */
// Scan position and pixel link
`timescale 1ns/1ps

interface scan_if;
    import video_pkg::*;
    import pixel_pkg::*;

    // position of the pixel the line buffer wants next.
    hpos_t  hscan;
    vpos_t  vscan;

    // pixel for that position and the level telling it is good.
    pixel_t pxl_data;
    logic   rom_ok;

    // the line buffer walks the scan position.
    modport buffer (
        output hscan,
        output vscan,
        input  pxl_data,
        input  rom_ok
    );

    // the fetch block answers with pixels.
    modport fetch (
        input  hscan,
        input  vscan,
        output pxl_data,
        output rom_ok
    );

endinterface

/* hdl/video_timing.sv */
// Raster timing generator
`timescale 1ns/1ps

module video_timing (
    input  logic             clk,
    input  logic             rst,
    output logic             pxl2_cen,
    output logic             pxl_cen,
    output video_pkg::hpos_t hdump,
    output video_pkg::vpos_t vdump
);
    import video_pkg::*;

    logic [cen_width-1:0] cen_cnt;

    // the divider cycles through cen_div states.
    // pxl2_cen fires on every odd state and pxl_cen on the last one,
    // so the two strobes line up once per pixel.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt  <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            if (cen_cnt == cen_width'(cen_div - 1)) begin
                cen_cnt <= '0;
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
            end
            pxl2_cen <= cen_cnt[0];
            pxl_cen  <= cen_cnt == cen_width'(cen_div - 1);
        end
    end

    // hdump counts pixels and vdump counts lines.
    // vdump only moves on the pixel where hdump wraps.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (hdump == hpos_t'(h_total - 1)) begin
                hdump <= '0;
                if (vdump == vpos_t'(v_total - 1)) begin
                    vdump <= '0;
                end else begin
                    vdump <= vdump + 1'b1;
                end
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // the line counter stays inside the short frame.
    vdump_range: assert property (@(posedge clk) disable iff (rst)
        int'(vdump) < v_total);

endmodule

/* tile_layer/line_ram.sv */
// Dual-port line memory
`timescale 1ns/1ps

module line_ram #(
    parameter int addr_width = 9
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  pixel_pkg::pixel_t     wr_data,
    input  logic [addr_width-1:0] rd_addr,
    output pixel_pkg::pixel_t     rd_data
);
    import pixel_pkg::*;

    // one pixel word per address.
    // The top address bit picks the half of the double buffer.
    pixel_t mem [2**addr_width];

    // write port.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, the data shows up one clk after the address.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* tile_layer/tile_line_buffer.sv */
// Double-buffered scan line store
`timescale 1ns/1ps

module tile_line_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl2_cen,
    input  video_pkg::hpos_t  hdump,
    input  video_pkg::vpos_t  vdump,
    scan_if.buffer            scan,
    output pixel_pkg::pixel_t pxl_dump
);
    import video_pkg::*;

    logic  line;
    logic  done;
    logic  line_start;
    logic  we;
    hpos_t hnext;

    // the fill starts over whenever the display reaches h_over.
    assign line_start = hdump == hpos_t'(h_over);
    assign hnext      = scan.hscan + 1'b1;

    // a pixel is taken on a pxl2_cen cycle when the fetch has it ready.
    // Nothing is written once the line is complete or while it restarts.
    assign we = pxl2_cen & scan.rom_ok & ~done & ~line_start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan.hscan <= '0;
            scan.vscan <= '0;
            line       <= 1'b0;
            done       <= 1'b0;
        end else begin
            // the fill always works on the line after the one on screen.
            // The last line of a frame prepares the first line of the next.
            if (vdump == vpos_t'(v_total - 1)) begin
                scan.vscan <= '0;
            end else begin
                scan.vscan <= vdump + 1'b1;
            end

            if (line_start) begin
                // swap halves only if the last fill reached the end.
                // Otherwise the old line stays on screen once more.
                if (done) begin
                    line <= ~line;
                end
                scan.hscan <= hpos_t'(h_over);
                done       <= 1'b0;
            end else if (we) begin
                scan.hscan <= hnext;
                if (hnext == hpos_t'(h_over)) begin
                    done <= 1'b1;
                end
            end
        end
    end

    // the fill half is selected by line and the display reads the other.
    line_ram #(
        .addr_width (h_width + 1)
    ) u_line_ram (
        .clk     (clk),
        .wr_en   (we),
        .wr_addr ({line, scan.hscan}),
        .wr_data (scan.pxl_data),
        .rd_addr ({~line, hdump}),
        .rd_data (pxl_dump)
    );

    // vscan lags a new vdump by one clk, so no pixel may be taken in that clk.
    vscan_settled: assert property (@(posedge clk) disable iff (rst)
        we |-> $stable(vdump));

endmodule

/* tile_layer/tile_fetch.sv */
// Tile map and graphics ROM fetch
`timescale 1ns/1ps

module tile_fetch (
    input  logic                  clk,
    input  logic                  rst,
    scan_if.fetch                 scan,
    input  logic                  map_we,
    input  pixel_pkg::map_addr_t  map_addr,
    input  pixel_pkg::map_entry_t map_din,
    output logic                  rom_cs,
    output pixel_pkg::rom_addr_t  rom_addr,
    input  pixel_pkg::rom_word_t  rom_data,
    input  logic                  rom_ok_in
);
    import pixel_pkg::*;

    map_entry_t           map_mem [map_words];
    map_addr_t            cur_map_addr;
    map_entry_t           cur_entry;
    rom_addr_t            need_addr;
    rom_word_t            row_word;
    rom_addr_t            row_tag;
    logic                 row_valid;
    logic                 req_new;
    logic                 hit;
    logic [col_width-1:0] nibble;

    // the map is written one entry at a time by the outside.
    always_ff @(posedge clk) begin
        if (map_we) begin
            map_mem[map_addr] <= map_din;
        end
    end

    // entry for the tile under the scan position.
    assign cur_map_addr = {scan.vscan[tile_bits +: map_col_bits],
                           scan.hscan[tile_bits +: map_col_bits]};
    assign cur_entry    = map_mem[cur_map_addr];

    // the ROM row needed is the tile code and the row inside the tile.
    assign need_addr = {cur_entry.code, scan.vscan[tile_bits-1:0]};
    assign hit       = row_valid && (row_tag == need_addr);

    // request control.
    // req_new masks rom_ok in the first cycle of a request, when it may
    // still belong to the previous address.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            req_new   <= 1'b0;
            row_valid <= 1'b0;
        end else begin
            req_new <= 1'b0;
            if (rom_cs) begin
                if (rom_ok_in && !req_new) begin
                    rom_cs    <= 1'b0;
                    row_valid <= 1'b1;
                end
            end else if (!hit) begin
                rom_cs  <= 1'b1;
                req_new <= 1'b1;
            end
        end
    end

    // the address is latched when a request opens and held until it closes.
    always_ff @(posedge clk) begin
        if (!rom_cs && !hit) begin
            rom_addr <= need_addr;
        end
        if (rom_cs && rom_ok_in && !req_new) begin
            row_word <= rom_data;
            row_tag  <= rom_addr;
        end
    end

    // low hscan bits pick the nibble, pixel 0 sits in the lowest one.
    assign nibble = row_word[{scan.hscan[tile_bits-1:0], 2'b00} +: col_width];

    // the pixel is good only while the cached row is the one needed now.
    assign scan.rom_ok   = hit;
    assign scan.pxl_data = {cur_entry.pal, nibble};

    // the ROM only raises rom_ok for a request that is open.
    // A late rise would be taken as data for the wrong row.
    rom_ok_requested: assert property (@(posedge clk) disable iff (rst)
        $rose(rom_ok_in) |-> $past(rom_cs));

endmodule

/* hdl/tilemap_video.sv */
// Tile layer video top level
`timescale 1ns/1ps

module tilemap_video (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  map_we,
    input  pixel_pkg::map_addr_t  map_addr,
    input  pixel_pkg::map_entry_t map_din,
    output logic                  rom_cs,
    output pixel_pkg::rom_addr_t  rom_addr,
    input  pixel_pkg::rom_word_t  rom_data,
    input  logic                  rom_ok,
    output logic                  pxl_cen,
    output video_pkg::hpos_t      hdump,
    output video_pkg::vpos_t      vdump,
    output pixel_pkg::pixel_t     pxl_dump
);

    // the fill side runs at the double pixel rate.
    logic pxl2_cen;

    // link between the fetch block and the line buffer.
    scan_if u_scan ();

    // raster counters and pixel strobes.
    video_timing u_video_timing (
        .clk      (clk),
        .rst      (rst),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .vdump    (vdump)
    );

    // map lookup and ROM row cache.
    tile_fetch u_tile_fetch (
        .clk       (clk),
        .rst       (rst),
        .scan      (u_scan.fetch),
        .map_we    (map_we),
        .map_addr  (map_addr),
        .map_din   (map_din),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok_in (rom_ok)
    );

    // a line is filled ahead and shown on the next one.
    tile_line_buffer u_tile_line_buffer (
        .clk      (clk),
        .rst      (rst),
        .pxl2_cen (pxl2_cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .scan     (u_scan.buffer),
        .pxl_dump (pxl_dump)
    );

endmodule

/* verification/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 8 ns clock period.
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset is held for the first five rising edges.
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* verification/tb_tilemap_video.sv */
// Tile layer video testbench
`timescale 1ns/1ps

module tb_tilemap_video;
    import video_pkg::*;
    import pixel_pkg::*;

    // one phase sets the ROM latency, writes some map entries and checks a frame.
    typedef struct packed {
        int mode;
        int lat;
        int write_line;
        int first_wr;
        int n_wr;
        int stall_line;
    } phase_t;

    typedef struct packed {
        map_addr_t  addr;
        map_entry_t entry;
    } wr_t;

    localparam int n_phases = 5;
    localparam int n_writes = 6;
    localparam real frame_ns = v_total * h_total * cen_div * 8.0;
    localparam real watchdog_ns = (n_phases * 2 + 2) * frame_ns;

    // mode 0 is a fixed latency and mode 1 a random one; stall_line -1 means no stall.
    localparam phase_t phase_tab [n_phases] = '{
        '{0, 2, 4, 0, 0, -1},
        '{1, 0, 2, 0, 0, -1},
        '{0, 3, 6, 0, 0, 5},
        '{0, 1, 8, 0, 3, -1},
        '{1, 0, 12, 3, 3, -1}
    };

    localparam wr_t wr_tab [n_writes] = '{
        '{10'd0,  '{4'h3, 8'h5a}},
        '{10'd7,  '{4'hf, 8'hc1}},
        '{10'd31, '{4'h9, 8'h02}},
        '{10'd33, '{4'h1, 8'h7e}},
        '{10'd63, '{4'h6, 8'hff}},
        '{10'd40, '{4'ha, 8'h10}}
    };

    logic       clk;
    logic       rst;
    logic       map_we = 1'b0;
    map_addr_t  map_addr = '0;
    map_entry_t map_din = '0;
    logic       rom_cs;
    rom_addr_t  rom_addr;
    rom_word_t  rom_data = '0;
    logic       rom_ok = 1'b0;
    logic       pxl_cen;
    hpos_t      hdump;
    vpos_t      vdump;
    pixel_t     pxl_dump;

    // ROM model controls, written by the main process.
    logic       rom_random = 1'b0;
    int         fixed_lat = 2;
    logic       rom_stall = 1'b0;
    int         seed = 32'ha524c02a;
    int         rnd;
    int         lat_now;
    int         wait_cnt;

    // reference state for the pixel checks.
    map_entry_t ref_map [map_words];
    pixel_t     exp_pxl;
    logic       check_on = 1'b0;
    int         stall_line = -1;
    int         n_checked = 0;

    // raster model for the timing checks.
    hpos_t      exp_h;
    vpos_t      exp_v;
    logic       prev_cen;
    int         clk_since;
    int         cen_count;

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    tilemap_video u_tilemap_video (
        .clk      (clk),
        .rst      (rst),
        .map_we   (map_we),
        .map_addr (map_addr),
        .map_din  (map_din),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .pxl_dump (pxl_dump)
    );

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_pixel(input pixel_t act, input pixel_t exp, input hpos_t h,
                               input vpos_t v);
        if (act !== exp) begin
            report_failure($sformatf("pixel (%0d,%0d) is %h, expected %h", h, v, act, exp));
        end
    endtask

    task automatic check_position(input hpos_t act_h, input vpos_t act_v,
                                  input hpos_t exp_hp, input vpos_t exp_vp);
        if (act_h !== exp_hp || act_v !== exp_vp) begin
            report_failure($sformatf("raster at (%0d,%0d), expected (%0d,%0d)",
                                     act_h, act_v, exp_hp, exp_vp));
        end
    endtask

    task automatic check_strobe(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            report_failure($sformatf("%s is %b, expected %b", what, act, exp));
        end
    endtask

    // every ROM nibble is code plus row plus pixel index, modulo 16.
    function automatic logic [3:0] rule_nibble(input tile_code_t code, input int row,
                                               input int col);
        return 4'(int'(code) + row + col);
    endfunction

    function automatic rom_word_t rom_rule_word(input rom_addr_t a);
        rom_word_t w;
        for (int i = 0; i < 8; i++) begin
            w[4*i +: 4] = rule_nibble(a[10:3], int'(a[2:0]), i);
        end
        return w;
    endfunction

    // expected pixel at screen position (h, v) from the map entry of tile (v/8, h/8).
    function automatic pixel_t ref_pixel(input hpos_t h, input vpos_t v);
        map_entry_t e;
        e = ref_map[{v[7:3], h[7:3]}];
        return {e.pal, rule_nibble(e.code, int'(v[2:0]), int'(h[2:0]))};
    endfunction

    task automatic write_map(input map_addr_t a, input map_entry_t e);
        @(posedge clk);
        map_we   <= 1'b1;
        map_addr <= a;
        map_din  <= e;
        ref_map[a] = e;
    endtask

    // waits for the edge on which hdump wraps into line v.
    task automatic wait_line_start(input int v);
        vpos_t prev;
        prev = vpos_t'((v + v_total - 1) % v_total);
        do begin
            @(posedge clk);
        end while (!(pxl_cen && hdump == hpos_t'(h_total - 1) && vdump == prev));
    endtask

    // waits for the first edge of pixel h_over on line v.
    task automatic wait_line_over(input int v);
        do begin
            @(posedge clk);
        end while (!(hdump == hpos_t'(h_over) && vdump == vpos_t'(v)));
    endtask

    // ROM model, answering an open request after a fixed or random number of clks.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            wait_cnt <= 0;
        end else if (!rom_cs) begin
            rom_ok   <= 1'b0;
            wait_cnt <= 0;
        end else if (!rom_ok && !rom_stall) begin
            if (wait_cnt == 0) begin
                if (rom_random) begin
                    rnd     = $random(seed);
                    lat_now = 1 + (rnd & 3);
                end else begin
                    lat_now = fixed_lat;
                end
            end
            if (wait_cnt + 1 >= lat_now) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_rule_word(rom_addr);
            end
            wait_cnt <= wait_cnt + 1;
        end
    end

    // raster timing follows the divider and wrap rules from reset on.
    always @(negedge clk) begin
        if (rst) begin
            exp_h     = '0;
            exp_v     = '0;
            prev_cen  = 1'b0;
            clk_since = 0;
            cen_count = 0;
        end else begin
            if (prev_cen) begin
                if (exp_h == hpos_t'(h_total - 1)) begin
                    exp_h = '0;
                    exp_v = (exp_v == vpos_t'(v_total - 1)) ? '0 : exp_v + 1'b1;
                end else begin
                    exp_h = exp_h + 1'b1;
                end
            end
            check_position(hdump, vdump, exp_h, exp_v);
            clk_since = clk_since + 1;
            if (pxl_cen) begin
                if (cen_count > 0 && clk_since != cen_div) begin
                    report_failure($sformatf("pxl_cen gap of %0d clks", clk_since));
                end
                clk_since = 0;
                cen_count = cen_count + 1;
            end
            prev_cen = pxl_cen;
        end
    end

    // pixels are sampled on the last clk of each hdump value.
    // In a stall phase the line after the stall must repeat the stalled line.
    always @(negedge clk) begin
        if (check_on && pxl_cen && hdump != hpos_t'(h_over)) begin
            if (stall_line >= 0 && int'(vdump) == stall_line + 1) begin
                exp_pxl = ref_pixel(hdump, vpos_t'(stall_line));
            end else begin
                exp_pxl = ref_pixel(hdump, vdump);
            end
            check_pixel(pxl_dump, exp_pxl, hdump, vdump);
            n_checked = n_checked + 1;
        end
    end

    initial begin
        @(negedge rst);
        @(negedge clk);
        check_position(hdump, vdump, '0, '0);
        check_strobe(pxl_cen, 1'b0, "pxl_cen after reset");
    end

    initial begin
        // the map rows on screen are filled before the first phase starts.
        for (int a = 0; a < 2 * h_total / 8; a++) begin
            write_map(map_addr_t'(a), '{4'(a + 2), 8'(a * 13 + 5)});
        end
        @(posedge clk);
        map_we <= 1'b0;

        for (int p = 0; p < n_phases; p++) begin
            wait_line_start(phase_tab[p].write_line);
            rom_random <= (phase_tab[p].mode == 1);
            fixed_lat  <= phase_tab[p].lat;
            for (int w = 0; w < phase_tab[p].n_wr; w++) begin
                write_map(wr_tab[phase_tab[p].first_wr + w].addr,
                          wr_tab[phase_tab[p].first_wr + w].entry);
            end
            @(posedge clk);
            map_we <= 1'b0;

            // a whole frame is checked once every line was refilled.
            wait_line_start(0);
            stall_line = phase_tab[p].stall_line;
            check_on   = 1'b1;
            if (stall_line >= 0) begin
                wait_line_over(stall_line - 1);
                rom_stall <= 1'b1;
                wait_line_over(stall_line);
                rom_stall <= 1'b0;
            end
            wait_line_start(0);
            check_on   = 1'b0;
            stall_line = -1;
        end

        if (n_checked == n_phases * v_total * (h_total - 1)) begin
            $display("No errors");
            $finish;
        end else begin
            report_failure($sformatf("only %0d pixels were checked", n_checked));
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the frames did not complete in time");
        $display("Errors found");
        $fatal(1);
    end

endmodule

/* src.f */
common/video_pkg.sv
common/pixel_pkg.sv
common/scan_if.sv
hdl/video_timing.sv
tile_layer/line_ram.sv
tile_layer/tile_line_buffer.sv
tile_layer/tile_fetch.sv
hdl/tilemap_video.sv
verification/tb_clock_gen.sv
verification/tb_tilemap_video.sv

/* Bender.yml */
package:
  name: tilemap_video

sources:
  - common/video_pkg.sv
  - common/pixel_pkg.sv
  - common/scan_if.sv
  - hdl/video_timing.sv
  - tile_layer/line_ram.sv
  - tile_layer/tile_line_buffer.sv
  - tile_layer/tile_fetch.sv
  - hdl/tilemap_video.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_tilemap_video.sv
